// File: src/desc_alloc_params.svh
// Pool geometry macros for the descriptor allocator, included by the package, RTL and testbench
`ifndef DESC_ALLOC_PARAMS_SVH
`define DESC_ALLOC_PARAMS_SVH

// Number of independent LIFO banks in the pool
`define BANKS_N 4

// Descriptor lines held by each bank
`define BANK_LINES_N 8

// Width of a bank index
// Must cover BANKS_N
`define BANK_ID_W 2

// Width of a line index within one bank
// Must cover BANK_LINES_N
`define LINE_ID_W 3

`endif

// File: src/desc_alloc_pkg.sv
// Shared types for the descriptor allocator; imported by every RTL module that needs them
`include "desc_alloc_params.svh"

package desc_alloc_pkg;

  // Bank index within the pool
  typedef logic [`BANK_ID_W-1:0] bank_id_t;

  // Line index within one bank
  typedef logic [`LINE_ID_W-1:0] line_id_t;

  // Descriptor pointer, bank in the upper bits
  typedef struct packed {
    bank_id_t bank_id;
    line_id_t line_id;
  } desc_ptr_t;

  // One flag per bank
  typedef logic [`BANKS_N-1:0] bank_vec_t;

  // Allocation answer, ok clear means the pool was empty
  typedef struct packed {
    logic      ok;
    desc_ptr_t ptr;
  } alloc_rsp_t;

  // Four-phase channel tracking in the decoder
  typedef enum logic [1:0] {IDLE, WAIT_DONE, WAIT_RELEASE} chan_state_t;

  // Post-reset fill sequencer
  typedef enum logic {FILL, DONE} init_state_t;

endpackage

// File: src/desc_init_seq.sv
// Post-reset sequencer that pushes lines 0 upward into every bank in parallel, busy while filling
`include "desc_alloc_params.svh"

module desc_init_seq import desc_alloc_pkg::*; (
    input  logic     clk
  , input  logic     i_rst_n
  , output logic     o_wen
  , output line_id_t o_wline
  , output logic     o_busy
);

  init_state_t state_q;
  line_id_t    line_q;

  // Walk every line once, then park in DONE until the next reset
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q <= FILL;
      line_q  <= '0;
    end else if (state_q == FILL) begin
      line_q <= line_q + 1'b1;
      // Last line written this cycle
      if (line_q == line_id_t'(`BANK_LINES_N - 1)) begin
        state_q <= DONE;
      end
    end
  end

  // Line number doubles as stack data, depth supplies the address
  assign o_wen   = (state_q == FILL);
  assign o_wline = line_q;
  assign o_busy  = (state_q == FILL);

endmodule

// File: src/desc_bank_arb.sv
// Round-robin picker of the next non-empty bank to pop; priority rotates only on a real pop
`include "desc_alloc_params.svh"

module desc_bank_arb import desc_alloc_pkg::*; (
    input  logic      clk
  , input  logic      i_rst_n
  , input  bank_vec_t i_req
  , input  logic      i_adv
  , output bank_vec_t o_gnt
);

  bank_id_t prio_q;
  bank_id_t gnt_id;

  // Scan from the priority bank upward, wrapping at the top
  always_comb begin : grant_search
    bank_id_t idx;
    logic     found;
    o_gnt  = '0;
    gnt_id = prio_q;
    found  = 1'b0;
    for (int i = 0; i < `BANKS_N; i++) begin
      // Wrap relies on a power-of-two bank count
      idx = bank_id_t'(prio_q + i);
      if (!found && i_req[idx]) begin
        found      = 1'b1;
        gnt_id     = idx;
        o_gnt[idx] = 1'b1;
      end
    end
  end

  // Move priority just past the bank that was popped
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      prio_q <= '0;
    end else if (i_adv) begin
      prio_q <= gnt_id + 1'b1;
    end
  end

endmodule

// File: src/desc_bank_stack.sv
// One bank's LIFO of free line ids; a pop presents the top line on o_rline one cycle later
`include "desc_alloc_params.svh"

module desc_bank_stack import desc_alloc_pkg::*; (
    input  logic     clk
  , input  logic     i_rst_n
  , input  logic     i_push
  , input  logic     i_pop
  , input  line_id_t i_wline
  , output line_id_t o_rline
  , output logic     o_empty
);

  // Depth counts 0 to BANK_LINES_N, one bit wider than a line id
  logic [`LINE_ID_W:0] depth_q;
  line_id_t            mem_q [`BANK_LINES_N];
  line_id_t            wr_idx;
  line_id_t            top_idx;

  // Next free slot and current top entry
  assign wr_idx  = depth_q[`LINE_ID_W-1:0];
  assign top_idx = line_id_t'(depth_q - 1'b1);

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      depth_q <= '0;
    end else if (i_push && !i_pop) begin
      depth_q <= depth_q + 1'b1;
    end else if (i_pop && !i_push) begin
      depth_q <= depth_q - 1'b1;
    end
  end

  // Line storage
  // Overflow is not guarded, no double free in this pool
  always_ff @(posedge clk) begin
    if (i_push && !i_pop) begin
      mem_q[wr_idx] <= i_wline;
    end
  end

  // Registered read of the entry being popped
  always_ff @(posedge clk) begin
    if (i_pop) begin
      o_rline <= mem_q[top_idx];
    end
  end

  assign o_empty = (depth_q == '0);

endmodule

// File: src/desc_alloc_pipe.sv
// Execute stage of the allocator where admission pops a bank and lookup forms the pointer
`include "desc_alloc_params.svh"

module desc_alloc_pipe import desc_alloc_pkg::*; (
    input  logic      clk
  , input  logic      i_rst_n
  , input  logic      i_alloc_go
  , input  logic      i_free_go
  , input  desc_ptr_t i_free_ptr
  , output desc_ptr_t o_lk_ptr
  , output logic      o_empty
  , output logic      o_busy
);

  // Init sequencer
  logic      init_wen;
  line_id_t  init_wline;
  logic      init_busy;

  // Bank steering
  logic      collision;
  bank_vec_t free_bank;
  bank_vec_t pop_req;
  bank_vec_t pop_gnt;
  bank_vec_t bank_push;
  bank_vec_t bank_pop;
  bank_vec_t bank_empty;
  bank_id_t  gnt_id;
  line_id_t  bank_wline;
  line_id_t  bank_rline [`BANKS_N];

  // Admission to lookup registers
  logic      lk_bypass_q;
  desc_ptr_t lk_bypass_ptr_q;
  bank_id_t  lk_bank_q;
  logic      empty_q;

  desc_init_seq desc_init_seq_inst (
      .clk     (clk)
    , .i_rst_n (i_rst_n)
    , .o_wen   (init_wen)
    , .o_wline (init_wline)
    , .o_busy  (init_busy)
  );

  // Alloc and free together send the freed pointer straight back out
  assign collision = i_alloc_go & i_free_go;

  // One-hot of the bank named by the returned pointer
  assign free_bank = bank_vec_t'(1) << i_free_ptr.bank_id;

  // Candidates are non-empty banks other than one being pushed this cycle
  assign pop_req = ~bank_empty & ~({`BANKS_N{i_free_go}} & free_bank);

  desc_bank_arb desc_bank_arb_inst (
      .clk     (clk)
    , .i_rst_n (i_rst_n)
    , .i_req   (pop_req)
    , .i_adv   (i_alloc_go & ~collision)
    , .o_gnt   (pop_gnt)
  );

  // Grant back to a bank index for the lookup stage
  always_comb begin
    gnt_id = '0;
    for (int b = 0; b < `BANKS_N; b++) begin
      if (pop_gnt[b]) begin
        gnt_id = bank_id_t'(b);
      end
    end
  end

  // Init data goes to every bank at once and the freed line otherwise
  assign bank_wline = init_wen ? init_wline : i_free_ptr.line_id;

  for (genvar b = 0; b < `BANKS_N; b++) begin : bank_gen
    // A bypassed free never reaches the stacks
    assign bank_push[b] = init_wen | (i_free_go & free_bank[b] & ~collision);
    assign bank_pop[b]  = i_alloc_go & pop_gnt[b] & ~collision;

    desc_bank_stack desc_bank_stack_inst (
        .clk     (clk)
      , .i_rst_n (i_rst_n)
      , .i_push  (bank_push[b])
      , .i_pop   (bank_pop[b])
      , .i_wline (bank_wline)
      , .o_rline (bank_rline[b])
      , .o_empty (bank_empty[b])
    );
  end

  // Admission records where the line is coming from
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      lk_bypass_q <= 1'b0;
      empty_q     <= 1'b1;
    end else begin
      lk_bypass_q <= collision;
      empty_q     <= &bank_empty;
    end
  end

  // Payload for the lookup stage is loaded only on an allocation
  always_ff @(posedge clk) begin
    if (i_alloc_go) begin
      lk_bank_q <= gnt_id;
    end
    if (collision) begin
      lk_bypass_ptr_q <= i_free_ptr;
    end
  end

  // Lookup picks the bypass pointer or the popped bank's read line
  assign o_lk_ptr = lk_bypass_q ? lk_bypass_ptr_q
                                : desc_ptr_t'{bank_id: lk_bank_q,
                                              line_id: bank_rline[lk_bank_q]};

  assign o_empty = empty_q;
  assign o_busy  = init_busy;

endmodule

// File: src/desc_cmd_decode.sv
// Decode stage: tracks both four-phase channels and issues one-cycle alloc/free operations
module desc_cmd_decode import desc_alloc_pkg::*; (
    input  logic      clk
  , input  logic      i_rst_n
  , input  logic      i_alloc_req
  , input  logic      i_free_req
  , input  desc_ptr_t i_free_ptr
  , input  logic      i_empty
  , input  logic      i_busy
  , output logic      o_alloc_go
  , output logic      o_alloc_fail
  , output logic      o_free_go
  , output desc_ptr_t o_free_ptr
  , output logic      o_alloc_release
  , output logic      o_free_release
);

  chan_state_t alloc_st_q;
  chan_state_t free_st_q;
  desc_ptr_t   free_ptr_q;
  logic        alloc_issue;
  logic        free_issue;

  // Shared channel sequence
  // Accept, issue for one cycle, then wait for req to drop
  function automatic chan_state_t chan_next(chan_state_t st, logic req, logic busy);
    chan_state_t nxt;
    nxt = st;
    case (st)
      IDLE:         if (req && !busy) nxt = WAIT_DONE;
      WAIT_DONE:    nxt = WAIT_RELEASE;
      WAIT_RELEASE: if (!req) nxt = IDLE;
      default:      nxt = IDLE;
    endcase
    return nxt;
  endfunction

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      alloc_st_q <= IDLE;
      free_st_q  <= IDLE;
    end else begin
      alloc_st_q <= chan_next(alloc_st_q, i_alloc_req, i_busy);
      free_st_q  <= chan_next(free_st_q, i_free_req, i_busy);
    end
  end

  // Pointer is stable while req is high, take it on accept
  always_ff @(posedge clk) begin
    if (free_st_q == IDLE && i_free_req && !i_busy) begin
      free_ptr_q <= i_free_ptr;
    end
  end

  assign alloc_issue = (alloc_st_q == WAIT_DONE);
  assign free_issue  = (free_st_q == WAIT_DONE);

  // Empty pool still serves an alloc paired with a free via bypass
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_alloc_go   <= 1'b0;
      o_alloc_fail <= 1'b0;
      o_free_go    <= 1'b0;
    end else begin
      o_alloc_go   <= alloc_issue & (~i_empty | free_issue);
      o_alloc_fail <= alloc_issue & i_empty & ~free_issue;
      o_free_go    <= free_issue;
    end
  end

  assign o_free_ptr = free_ptr_q;

  // Client has dropped req, tell the result stage to lower ack
  assign o_alloc_release = (alloc_st_q == WAIT_RELEASE) & ~i_alloc_req;
  assign o_free_release  = (free_st_q == WAIT_RELEASE) & ~i_free_req;

endmodule

// File: src/desc_result.sv
// Result stage: registers the allocation answer and raises or drops both channel acks
module desc_result import desc_alloc_pkg::*; (
    input  logic       clk
  , input  logic       i_rst_n
  , input  logic       i_alloc_go
  , input  logic       i_alloc_fail
  , input  logic       i_free_go
  , input  desc_ptr_t  i_lk_ptr
  , input  logic       i_alloc_release
  , input  logic       i_free_release
  , output logic       o_alloc_ack
  , output alloc_rsp_t o_alloc_rsp
  , output logic       o_free_ack
);

  // Align with the lookup pointer, one cycle behind go
  logic alloc_go_q;
  logic alloc_fail_q;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      alloc_go_q   <= 1'b0;
      alloc_fail_q <= 1'b0;
      o_alloc_ack  <= 1'b0;
      o_free_ack   <= 1'b0;
    end else begin
      alloc_go_q   <= i_alloc_go;
      alloc_fail_q <= i_alloc_fail;
      if (alloc_go_q || alloc_fail_q) begin
        o_alloc_ack <= 1'b1;
      end else if (i_alloc_release) begin
        o_alloc_ack <= 1'b0;
      end
      if (i_free_go) begin
        o_free_ack <= 1'b1;
      end else if (i_free_release) begin
        o_free_ack <= 1'b0;
      end
    end
  end

  // Response holds until the next allocation completes
  always_ff @(posedge clk) begin
    if (alloc_go_q) begin
      o_alloc_rsp <= '{ok: 1'b1, ptr: i_lk_ptr};
    end else if (alloc_fail_q) begin
      o_alloc_rsp <= '0;
    end
  end

endmodule

// File: src/desc_alloc_top.sv
// Descriptor allocator top: decode, execute and result stages behind two four-phase channels
module desc_alloc_top import desc_alloc_pkg::*; (
    input  logic       clk
  , input  logic       i_rst_n
  , input  logic       i_alloc_req
  , input  logic       i_free_req
  , input  desc_ptr_t  i_free_ptr
  , output logic       o_alloc_ack
  , output alloc_rsp_t o_alloc_rsp
  , output logic       o_free_ack
  , output logic       o_busy
);

  // Decode to execute and result
  logic      alloc_go;
  logic      alloc_fail;
  logic      free_go;
  desc_ptr_t free_ptr;
  logic      alloc_release;
  logic      free_release;

  // Execute back to decode and on to result
  logic      pool_empty;
  logic      busy;
  desc_ptr_t lk_ptr;

  desc_cmd_decode desc_cmd_decode_inst (
      .clk             (clk)
    , .i_rst_n         (i_rst_n)
    , .i_alloc_req     (i_alloc_req)
    , .i_free_req      (i_free_req)
    , .i_free_ptr      (i_free_ptr)
    , .i_empty         (pool_empty)
    , .i_busy          (busy)
    , .o_alloc_go      (alloc_go)
    , .o_alloc_fail    (alloc_fail)
    , .o_free_go       (free_go)
    , .o_free_ptr      (free_ptr)
    , .o_alloc_release (alloc_release)
    , .o_free_release  (free_release)
  );

  desc_alloc_pipe desc_alloc_pipe_inst (
      .clk        (clk)
    , .i_rst_n    (i_rst_n)
    , .i_alloc_go (alloc_go)
    , .i_free_go  (free_go)
    , .i_free_ptr (free_ptr)
    , .o_lk_ptr   (lk_ptr)
    , .o_empty    (pool_empty)
    , .o_busy     (busy)
  );

  desc_result desc_result_inst (
      .clk             (clk)
    , .i_rst_n         (i_rst_n)
    , .i_alloc_go      (alloc_go)
    , .i_alloc_fail    (alloc_fail)
    , .i_free_go       (free_go)
    , .i_lk_ptr        (lk_ptr)
    , .i_alloc_release (alloc_release)
    , .i_free_release  (free_release)
    , .o_alloc_ack     (o_alloc_ack)
    , .o_alloc_rsp     (o_alloc_rsp)
    , .o_free_ack      (o_free_ack)
  );

  assign o_busy = busy;

endmodule

// File: dv/tb_desc_alloc.sv
// Self-checking testbench for the descriptor allocator and the top of every simulation run
`include "desc_alloc_params.svh"

module tb_desc_alloc import desc_alloc_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int POOL_N       = `BANKS_N * `BANK_LINES_N;
  localparam int ACK_WAIT_MAX = 40;
  // Count of four-phase transactions over all tests
  localparam int TXN_N        = 101;
  localparam int INIT_CYCLES  = 5 + `BANK_LINES_N;

  logic       clk;
  logic       rst_n;
  logic       alloc_req;
  logic       free_req;
  desc_ptr_t  free_ptr;
  logic       alloc_ack;
  alloc_rsp_t alloc_rsp;
  logic       free_ack;
  logic       busy;
  logic       alloc_cand;
  logic       free_cand;

  int errors;
  int tests_run;
  int tests_passed;
  int seed;

  // Reference pool with one LIFO per bank and the round-robin pointer
  line_id_t model_q [`BANKS_N][$];
  int       model_prio;

  desc_alloc_top desc_alloc_top_inst (
      .clk         (clk)
    , .i_rst_n     (rst_n)
    , .i_alloc_req (alloc_req)
    , .i_free_req  (free_req)
    , .i_free_ptr  (free_ptr)
    , .o_alloc_ack (alloc_ack)
    , .o_alloc_rsp (alloc_rsp)
    , .o_free_ack  (free_ack)
    , .o_busy      (busy)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // A channel is taken on the first edge that sees req high outside init
  assign alloc_cand = alloc_req & ~busy;
  assign free_cand  = free_req & ~busy;

  // Ack only rises on a request that is still held
  assert property (@(posedge clk) disable iff (!rst_n) $rose(alloc_ack) |-> $past(alloc_req))
    else begin
      $display("ERROR alloc ack rose while alloc req was low");
      errors++;
    end
  assert property (@(posedge clk) disable iff (!rst_n) $rose(free_ack) |-> $past(free_req))
    else begin
      $display("ERROR free ack rose while free req was low");
      errors++;
    end

  // Alloc ack is set 3 edges after acceptance and sampled high one edge later
  assert property (@(posedge clk) disable iff (!rst_n)
      $rose(alloc_ack) == ($past(alloc_cand, 4) && !$past(alloc_cand, 5)))
    else begin
      $display("ERROR alloc ack did not rise exactly 3 edges after acceptance");
      errors++;
    end
  // Free ack is one edge quicker
  assert property (@(posedge clk) disable iff (!rst_n)
      $rose(free_ack) == ($past(free_cand, 3) && !$past(free_cand, 4)))
    else begin
      $display("ERROR free ack did not rise exactly 2 edges after acceptance");
      errors++;
    end

  assert property (@(posedge clk) disable iff (!rst_n)
      (alloc_ack && $past(alloc_ack)) |-> $stable(alloc_rsp))
    else begin
      $display("ERROR alloc response changed while ack was high");
      errors++;
    end

  // Ack drops on the edge after req is seen low
  assert property (@(posedge clk) disable iff (!rst_n)
      $fell(alloc_ack) == (!$past(alloc_req) && $past(alloc_req, 2)))
    else begin
      $display("ERROR alloc ack did not fall one edge after req dropped");
      errors++;
    end
  assert property (@(posedge clk) disable iff (!rst_n)
      $fell(free_ack) == (!$past(free_req) && $past(free_req, 2)))
    else begin
      $display("ERROR free ack did not fall one edge after req dropped");
      errors++;
    end

  // Fresh pool holds lines 0 upward with line 7 on top of each bank
  function automatic void model_init();
    for (int b = 0; b < `BANKS_N; b++) begin
      model_q[b].delete();
      for (int l = 0; l < `BANK_LINES_N; l++) begin
        model_q[b].push_back(line_id_t'(l));
      end
    end
    model_prio = 0;
  endfunction

  function automatic void model_free(input desc_ptr_t ptr);
    model_q[ptr.bank_id].push_back(ptr.line_id);
  endfunction

  // Pop the first non-empty bank from the priority pointer and move priority past it
  function automatic alloc_rsp_t model_alloc();
    alloc_rsp_t rsp;
    int         b;
    rsp = '0;
    for (int i = 0; i < `BANKS_N; i++) begin
      b = (model_prio + i) % `BANKS_N;
      if (!rsp.ok && model_q[b].size() > 0) begin
        rsp.ok          = 1'b1;
        rsp.ptr.bank_id = bank_id_t'(b);
        rsp.ptr.line_id = model_q[b].pop_back();
        model_prio      = (b + 1) % `BANKS_N;
      end
    end
    return rsp;
  endfunction

  // Allocation k from a fresh pool
  function automatic alloc_rsp_t rr_expect(input int k);
    alloc_rsp_t rsp;
    rsp.ok          = 1'b1;
    rsp.ptr.bank_id = bank_id_t'(k % `BANKS_N);
    rsp.ptr.line_id = line_id_t'(`BANK_LINES_N - 1 - k / `BANKS_N);
    return rsp;
  endfunction

  // Runs from a falling edge until the falling edge where ack matches
  task automatic wait_ack(input bit is_free, input logic level, input string name);
    int cycles;
    cycles = 0;
    while ((is_free ? free_ack : alloc_ack) !== level && cycles < ACK_WAIT_MAX) begin
      @(negedge clk);
      cycles++;
    end
    assert ((is_free ? free_ack : alloc_ack) === level) else begin
      $display("ERROR %s: %s ack did not go to %0b within %0d cycles",
               name, is_free ? "free" : "alloc", level, ACK_WAIT_MAX);
      errors++;
    end
  endtask

  task automatic check_rsp(input string name, input alloc_rsp_t exp, input alloc_rsp_t got);
    assert (got === exp) else begin
      $display("MISMATCH %s: expected ok=%0b ptr=%0d:%0d actual ok=%0b ptr=%0d:%0d",
               name, exp.ok, exp.ptr.bank_id, exp.ptr.line_id,
               got.ok, got.ptr.bank_id, got.ptr.line_id);
      errors++;
    end
  endtask

  // Second half of an allocation once req is raised
  task automatic complete_alloc(input string name, input alloc_rsp_t exp,
                                output alloc_rsp_t got);
    wait_ack(1'b0, 1'b1, name);
    got = alloc_rsp;
    check_rsp(name, exp, got);
    alloc_req = 1'b0;
    wait_ack(1'b0, 1'b0, name);
  endtask

  task automatic do_alloc(input string name, input alloc_rsp_t exp, output alloc_rsp_t got);
    alloc_req = 1'b1;
    complete_alloc(name, exp, got);
  endtask

  task automatic do_free(input string name, input desc_ptr_t ptr);
    free_ptr = ptr;
    free_req = 1'b1;
    wait_ack(1'b1, 1'b1, name);
    free_req = 1'b0;
    wait_ack(1'b1, 1'b0, name);
  endtask

  // Both requests rise on the same edge so decode issues them together
  task automatic do_alloc_free(input string name, input desc_ptr_t ptr, input alloc_rsp_t exp);
    free_ptr  = ptr;
    free_req  = 1'b1;
    alloc_req = 1'b1;
    wait_ack(1'b0, 1'b1, name);
    wait_ack(1'b1, 1'b1, name);
    check_rsp(name, exp, alloc_rsp);
    // Requests stay high for a while so the response is held under a high ack
    repeat (2) @(negedge clk);
    alloc_req = 1'b0;
    free_req  = 1'b0;
    wait_ack(1'b0, 1'b0, name);
    wait_ack(1'b1, 1'b0, name);
  endtask

  task automatic finish_test(input string name, input int start_errs);
    tests_run++;
    if (errors == start_errs) begin
      tests_passed++;
      $display("PASS %s", name);
    end else begin
      $display("FAIL %s with %0d errors", name, errors - start_errs);
    end
  endtask

  initial begin
    repeat (INIT_CYCLES + 40 * TXN_N) @(posedge clk);
    $display("ERROR watchdog expired after %0d cycles", INIT_CYCLES + 40 * TXN_N);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    alloc_rsp_t exp;
    alloc_rsp_t got;
    desc_ptr_t  free_list [POOL_N];
    desc_ptr_t  tmp;
    bit         seen [POOL_N];
    int         cycles;
    int         j;
    int         start_errs;
    errors       = 0;
    tests_run    = 0;
    tests_passed = 0;
    seed         = 32'h3eff;
    rst_n        = 1'b0;
    alloc_req    = 1'b0;
    free_req     = 1'b0;
    free_ptr     = '0;
    model_init();
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    // Busy lasts one cycle per line while an early request waits
    start_errs = errors;
    assert (busy === 1'b1) else begin
      $display("ERROR reset_init: busy was low right after reset");
      errors++;
    end
    alloc_req = 1'b1;
    cycles    = 0;
    while (busy === 1'b1 && cycles < 4 * `BANK_LINES_N) begin
      @(negedge clk);
      cycles++;
      assert (alloc_ack === 1'b0) else begin
        $display("ERROR reset_init: alloc ack rose during init");
        errors++;
      end
    end
    assert (cycles == `BANK_LINES_N) else begin
      $display("MISMATCH reset_init: expected busy cycles %0d actual %0d",
               `BANK_LINES_N, cycles);
      errors++;
    end
    void'(model_alloc());
    complete_alloc("reset_init", rr_expect(0), got);
    finish_test("reset_init", start_errs);

    // Drain the rest of the pool and then make one refused request
    start_errs = errors;
    for (int k = 1; k < POOL_N; k++) begin
      void'(model_alloc());
      do_alloc("rr_lifo", rr_expect(k), got);
    end
    void'(model_alloc());
    do_alloc("rr_lifo", '0, got);
    finish_test("rr_lifo", start_errs);

    // Shuffled return of every pointer
    start_errs = errors;
    for (int i = 0; i < POOL_N; i++) begin
      free_list[i].bank_id = bank_id_t'(i / `BANK_LINES_N);
      free_list[i].line_id = line_id_t'(i % `BANK_LINES_N);
      seen[i]              = 1'b0;
    end
    for (int i = POOL_N - 1; i > 0; i--) begin
      j = $random(seed) % (i + 1);
      if (j < 0) begin
        j = -j;
      end
      tmp          = free_list[i];
      free_list[i] = free_list[j];
      free_list[j] = tmp;
    end
    for (int i = 0; i < POOL_N; i++) begin
      model_free(free_list[i]);
      do_free("free_realloc", free_list[i]);
    end
    for (int i = 0; i < POOL_N; i++) begin
      exp = model_alloc();
      do_alloc("free_realloc", exp, got);
      seen[{got.ptr.bank_id, got.ptr.line_id}] = 1'b1;
    end
    for (int i = 0; i < POOL_N; i++) begin
      assert (seen[i]) else begin
        $display("ERROR free_realloc: freed pointer %0d never came back", i);
        errors++;
      end
    end
    finish_test("free_realloc", start_errs);

    // One line into an empty pool comes straight back out
    start_errs = errors;
    model_free(free_list[0]);
    do_free("single_free", free_list[0]);
    exp = model_alloc();
    do_alloc("single_free", exp, got);
    finish_test("single_free", start_errs);

    // Freed pointer bypasses the stacks and the pool stays empty
    start_errs = errors;
    exp.ok  = 1'b1;
    exp.ptr = free_list[1];
    do_alloc_free("collision", free_list[1], exp);
    void'(model_alloc());
    do_alloc("collision", '0, got);
    finish_test("collision", start_errs);

    // Let the last ack fall reach the protocol checks
    repeat (2) @(negedge clk);
    $display("Tests run %0d, passed %0d, errors %0d", tests_run, tests_passed, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+src
src/desc_alloc_pkg.sv
src/desc_init_seq.sv
src/desc_bank_arb.sv
src/desc_bank_stack.sv
src/desc_alloc_pipe.sv
src/desc_cmd_decode.sv
src/desc_result.sv
src/desc_alloc_top.sv
dv/tb_desc_alloc.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the descriptor allocator testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_desc_alloc --Mdir obj_dir -o tb_desc_alloc_sim -f verilog.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

sim_out="$(./obj_dir/tb_desc_alloc_sim)"
status=$?
printf '%s\n' "$sim_out"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Finished with no errors"; then
  exit 0
fi
echo "Simulation reported failure"
exit 1
